//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

  // Primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    op_special = 6'h00,  // R-type, decoded further by funct
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_slti    = 6'h0A,
    op_andi    = 6'h0C,
    op_ori     = 6'h0D,
    op_lui     = 6'h0F,
    op_lb      = 6'h20,
    op_lw      = 6'h23,
    op_lbu     = 6'h24,
    op_sw      = 6'h2B
  } opcode_t;

  // Function field for op_special, instr[5:0]
  typedef enum logic [5:0] {
    fn_sll  = 6'h00,
    fn_srl  = 6'h02,
    fn_jr   = 6'h08,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_slt  = 6'h2A,
    fn_sltu = 6'h2B
  } funct_t;

  // ALU operation select
  typedef enum logic [3:0] {
    alu_add,   // Also used for address generation
    alu_sub,   // Branch compare goes through here
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_lui    // Immediate into upper half
  } alu_op_t;

  // How the loaded word is formed
  typedef enum logic [1:0] {
    ld_word,
    ld_byte_s,  // lb
    ld_byte_u   // lbu
  } load_kind_t;

  localparam logic [4:0] reg_v0 = 5'd2;
  localparam logic [4:0] reg_v3 = 5'd3;
  localparam logic [4:0] reg_ra = 5'd31;  // Link register for jal

endpackage

`default_nettype wire

//--- common/ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

// Decoded control word, one instruction at a time
interface ctrl_if;

  logic                 reg_write;      // Write back this cycle
  logic                 reg_dst_rd;     // Destination is rd, else rt
  logic                 link;           // jal writes PC+4 to ra
  logic                 alu_src_imm;    // Operand b from immediate
  logic                 imm_zero_ext;   // Zero extend for andi and ori
  mips_pkg::alu_op_t    alu_op;
  logic                 mem_to_reg;     // Write back the loaded value
  mips_pkg::load_kind_t load_kind;
  logic                 mem_write;
  logic                 mem_read;
  logic                 pc_src_branch;  // Branch taken
  logic                 jump;           // j and jal
  logic                 jump_reg;       // jr

  modport dec (
    output reg_write, reg_dst_rd, link, alu_src_imm, imm_zero_ext, alu_op,
    output mem_to_reg, load_kind, mem_write, mem_read,
    output pc_src_branch, jump, jump_reg
  );

  modport dp (
    input reg_write, reg_dst_rd, link, alu_src_imm, imm_zero_ext, alu_op,
    input mem_to_reg, load_kind, mem_write, mem_read,
    input pc_src_branch, jump, jump_reg
  );

endinterface

`default_nettype wire

//--- datapath/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic        clk,
  input  logic        reset,
  input  logic        write_en,
  input  logic [4:0]  read_a,
  input  logic [4:0]  read_b,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data,
  output logic [31:0] data_a,
  output logic [31:0] data_b,
  output logic [31:0] v0,
  output logic [31:0] v3
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'h0;  // All registers start at zero
      end
    end else if (write_en && write_addr != 5'd0) begin
      regs[write_addr] <= write_data;  // Register 0 is never written
    end
  end

  // Asynchronous read ports
  assign data_a = regs[read_a];
  assign data_b = regs[read_b];

  // Taps for the top-level result ports
  assign v0 = regs[mips_pkg::reg_v0];
  assign v3 = regs[mips_pkg::reg_v3];

endmodule

`default_nettype wire

//--- datapath/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  mips_pkg::alu_op_t op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  input  logic [4:0]        shamt,
  output logic [31:0]       result,
  output logic              zero
);

  logic [31:0] sum;
  logic [31:0] diff;
  logic        less_signed;
  logic        less_unsigned;

  assign sum  = a + b;
  assign diff = a - b;

  assign less_signed   = $signed(a) < $signed(b);
  assign less_unsigned = a < b;

  always_comb begin
    case (op)
      mips_pkg::alu_add:  result = sum;
      mips_pkg::alu_sub:  result = diff;
      mips_pkg::alu_and:  result = a & b;
      mips_pkg::alu_or:   result = a | b;
      mips_pkg::alu_xor:  result = a ^ b;
      mips_pkg::alu_slt:  result = {31'h0, less_signed};
      mips_pkg::alu_sltu: result = {31'h0, less_unsigned};
      mips_pkg::alu_sll:  result = b << shamt;  // Shifts act on rt
      mips_pkg::alu_srl:  result = b >> shamt;  // Logical, zero fill
      mips_pkg::alu_lui:  result = {b[15:0], 16'h0000};
      default:            result = sum;
    endcase
  end

  // Used by beq and bne after a subtract
  assign zero = (result == 32'h0);

endmodule

`default_nettype wire

//--- datapath/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath #(
  parameter logic [31:0] reset_vector = 32'hBFC00000
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        run,        // Retire the current instruction at this edge
  input  logic [31:0] instr,
  ctrl_if.dp          ctl,
  input  logic [31:0] read_data,  // Already in core byte order
  output logic        zero,
  output logic [31:0] pc,
  output logic [31:0] mem_address,
  output logic [31:0] write_data,
  output logic [31:0] register_v0,
  output logic [31:0] register_v3
);

  logic [4:0]  rs, rt, rd, shamt;
  logic [4:0]  write_addr;
  logic [15:0] imm;
  logic [31:0] imm_ext, pc_plus4, branch_target, jump_target, next_pc;
  logic [31:0] rs_data, rt_data, alu_b, alu_result;
  logic [7:0]  load_byte;
  logic [31:0] load_value, write_back;

  assign rs    = instr[25:21];
  assign rt    = instr[20:16];
  assign rd    = instr[15:11];
  assign shamt = instr[10:6];
  assign imm   = instr[15:0];

  assign imm_ext = ctl.imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};  // Same 256 MB region

  // No delay slot, so the target is the very next fetch
  always_comb begin
    if (ctl.jump_reg) next_pc = rs_data;
    else if (ctl.jump) next_pc = jump_target;
    else if (ctl.pc_src_branch) next_pc = branch_target;
    else next_pc = pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (reset) pc <= reset_vector;
    else if (run) pc <= next_pc;  // Holds on stall and after halt
  end

  reg_file reg_file_inst (
    .clk        (clk),
    .reset      (reset),
    .write_en   (run & ctl.reg_write),
    .read_a     (rs),
    .read_b     (rt),
    .write_addr (write_addr),
    .write_data (write_back),
    .data_a     (rs_data),
    .data_b     (rt_data),
    .v0         (register_v0),
    .v3         (register_v3)
  );

  assign alu_b = ctl.alu_src_imm ? imm_ext : rt_data;

  alu alu_inst (
    .op     (ctl.alu_op),
    .a      (rs_data),
    .b      (alu_b),
    .shamt  (shamt),
    .result (alu_result),
    .zero   (zero)
  );

  assign mem_address = alu_result;
  assign write_data  = rt_data;  // sw stores rt

  // Byte 0 of a word sits in bits 31:24 inside the core
  always_comb begin
    case (alu_result[1:0])
      2'd0:    load_byte = read_data[31:24];
      2'd1:    load_byte = read_data[23:16];
      2'd2:    load_byte = read_data[15:8];
      default: load_byte = read_data[7:0];
    endcase
    case (ctl.load_kind)
      mips_pkg::ld_byte_s: load_value = {{24{load_byte[7]}}, load_byte};
      mips_pkg::ld_byte_u: load_value = {24'h000000, load_byte};
      default:             load_value = read_data;
    endcase
  end

  assign write_addr = ctl.link ? mips_pkg::reg_ra : (ctl.reg_dst_rd ? rd : rt);
  assign write_back = ctl.link ? pc_plus4 : (ctl.mem_to_reg ? load_value : alu_result);

  // A misaligned jr target would break fetch
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("PC not word aligned: %h", pc);

endmodule

`default_nettype wire

//--- source/controller.sv
`timescale 1ns/100ps
`default_nettype none

module controller (
  input  logic [31:0] instr,
  input  logic        zero,  // ALU result of rs - rt is zero
  ctrl_if.dec         ctl
);

  mips_pkg::opcode_t op;
  mips_pkg::funct_t  funct;
  logic              is_beq;
  logic              is_bne;
  logic              legal;  // Opcode and funct are in the supported set

  assign op    = mips_pkg::opcode_t'(instr[31:26]);
  assign funct = mips_pkg::funct_t'(instr[5:0]);

  always_comb begin
    ctl.reg_write    = 1'b0;
    ctl.reg_dst_rd   = 1'b0;
    ctl.link         = 1'b0;
    ctl.alu_src_imm  = 1'b0;
    ctl.imm_zero_ext = 1'b0;  // Sign extension unless andi or ori
    ctl.alu_op       = mips_pkg::alu_add;
    ctl.mem_to_reg   = 1'b0;
    ctl.load_kind    = mips_pkg::ld_word;
    ctl.mem_write    = 1'b0;
    ctl.mem_read     = 1'b0;
    ctl.jump         = 1'b0;
    ctl.jump_reg     = 1'b0;
    is_beq           = 1'b0;
    is_bne           = 1'b0;
    legal            = 1'b1;
    case (op)
      mips_pkg::op_special: begin
        ctl.reg_write  = 1'b1;
        ctl.reg_dst_rd = 1'b1;
        case (funct)
          mips_pkg::fn_addu: ctl.alu_op = mips_pkg::alu_add;
          mips_pkg::fn_subu: ctl.alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:  ctl.alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:   ctl.alu_op = mips_pkg::alu_or;
          mips_pkg::fn_xor:  ctl.alu_op = mips_pkg::alu_xor;
          mips_pkg::fn_slt:  ctl.alu_op = mips_pkg::alu_slt;
          mips_pkg::fn_sltu: ctl.alu_op = mips_pkg::alu_sltu;
          mips_pkg::fn_sll:  ctl.alu_op = mips_pkg::alu_sll;
          mips_pkg::fn_srl:  ctl.alu_op = mips_pkg::alu_srl;
          mips_pkg::fn_jr: begin
            ctl.reg_write = 1'b0;  // jr has no destination
            ctl.jump_reg  = 1'b1;
          end
          default: begin
            ctl.reg_write = 1'b0;
            legal         = 1'b0;
          end
        endcase
      end
      mips_pkg::op_addiu: begin
        ctl.reg_write   = 1'b1;
        ctl.alu_src_imm = 1'b1;
      end
      mips_pkg::op_slti: begin
        ctl.reg_write   = 1'b1;
        ctl.alu_src_imm = 1'b1;
        ctl.alu_op      = mips_pkg::alu_slt;
      end
      mips_pkg::op_andi: begin
        ctl.reg_write    = 1'b1;
        ctl.alu_src_imm  = 1'b1;
        ctl.imm_zero_ext = 1'b1;
        ctl.alu_op       = mips_pkg::alu_and;
      end
      mips_pkg::op_ori: begin
        ctl.reg_write    = 1'b1;
        ctl.alu_src_imm  = 1'b1;
        ctl.imm_zero_ext = 1'b1;
        ctl.alu_op       = mips_pkg::alu_or;
      end
      mips_pkg::op_lui: begin
        ctl.reg_write   = 1'b1;
        ctl.alu_src_imm = 1'b1;
        ctl.alu_op      = mips_pkg::alu_lui;
      end
      mips_pkg::op_lw, mips_pkg::op_lb, mips_pkg::op_lbu: begin
        ctl.reg_write   = 1'b1;
        ctl.alu_src_imm = 1'b1;  // Address is rs + offset
        ctl.mem_to_reg  = 1'b1;
        ctl.mem_read    = 1'b1;
        if (op == mips_pkg::op_lb) ctl.load_kind = mips_pkg::ld_byte_s;
        else if (op == mips_pkg::op_lbu) ctl.load_kind = mips_pkg::ld_byte_u;
      end
      mips_pkg::op_sw: begin
        ctl.alu_src_imm = 1'b1;
        ctl.mem_write   = 1'b1;
      end
      mips_pkg::op_beq: begin
        ctl.alu_op = mips_pkg::alu_sub;
        is_beq     = 1'b1;
      end
      mips_pkg::op_bne: begin
        ctl.alu_op = mips_pkg::alu_sub;
        is_bne     = 1'b1;
      end
      mips_pkg::op_j: ctl.jump = 1'b1;
      mips_pkg::op_jal: begin
        ctl.jump      = 1'b1;
        ctl.link      = 1'b1;  // ra gets PC+4
        ctl.reg_write = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  // Branch decision from the subtract result
  assign ctl.pc_src_branch = (is_beq & zero) | (is_bne & ~zero);

  // Fetched word must decode to a supported instruction
  always_comb begin
    if (!$isunknown(instr)) begin
      assert final (legal)
        else $error("Unsupported instruction %h", instr);
    end
  end

endmodule

`default_nettype wire

//--- source/mips_cpu_harvard.sv
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_harvard #(
  parameter logic [31:0] reset_vector = 32'hBFC00000
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic [31:0] instr_readdata,
  input  logic [31:0] data_readdata,
  output logic        active,
  output logic [31:0] register_v0,
  output logic [31:0] register_v3,
  output logic [31:0] instr_address,
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata
);

  logic [31:0] instr_be;       // Fetched word in core byte order
  logic [31:0] read_data_be;
  logic [31:0] write_data_be;
  logic        zero;
  logic        running;        // Executing, not at the halt address
  logic        run;

  ctrl_if ctl ();

  // Memory is little-endian, the core sees byte 0 in the top byte
  assign instr_be = {instr_readdata[7:0], instr_readdata[15:8],
                     instr_readdata[23:16], instr_readdata[31:24]};
  assign read_data_be = {data_readdata[7:0], data_readdata[15:8],
                         data_readdata[23:16], data_readdata[31:24]};
  assign data_writedata = {write_data_be[7:0], write_data_be[15:8],
                           write_data_be[23:16], write_data_be[31:24]};

  controller controller_inst (
    .instr (instr_be),
    .zero  (zero),
    .ctl   (ctl)
  );

  datapath #(
    .reset_vector (reset_vector)
  ) datapath_inst (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .instr       (instr_be),
    .ctl         (ctl),
    .read_data   (read_data_be),
    .zero        (zero),
    .pc          (instr_address),
    .mem_address (data_address),
    .write_data  (write_data_be),
    .register_v0 (register_v0),
    .register_v3 (register_v3)
  );

  // Address 0 is the halt address and is never executed
  assign running    = active & ~reset & (instr_address != 32'h0);
  assign run        = running & clk_enable;
  assign data_write = running & ctl.mem_write;
  assign data_read  = running & ctl.mem_read;

  always_ff @(posedge clk) begin
    if (reset) active <= 1'b1;
    else if (clk_enable && instr_address == 32'h0) active <= 1'b0;  // Sticky until reset
  end

  // A halted core fetches nothing new
  assert property (@(posedge clk) disable iff (reset) !active |=> $stable(instr_address));

  // A stalled cycle leaves the fetch address alone
  assert property (@(posedge clk) disable iff (reset) !clk_enable |=> $stable(instr_address));

endmodule

`default_nettype wire

//--- test/program_table.svh
`ifndef program_table_svh
`define program_table_svh

localparam int num_tests = 6;
localparam int rom_words = 96;

string       test_names   [num_tests];
int          prog_start   [num_tests];  // First word of the program in prog_rom
int          prog_len     [num_tests];
bit          stall_on     [num_tests];  // Random clk_enable gaps
logic [31:0] init_addr    [num_tests];  // Preset data word, core byte order
logic [31:0] init_word    [num_tests];
bit          mem_chk_on   [num_tests];
logic [31:0] mem_chk_addr [num_tests];
logic [31:0] mem_chk_word [num_tests];  // Raw little-endian memory word
int          exp_loads    [num_tests];  // Loads the program retires
logic [31:0] exp_v0       [num_tests];
logic [31:0] exp_v3       [num_tests];
logic [31:0] prog_rom     [rom_words];  // Program words in core byte order
int          rom_fill;

// MIPS-I instruction encoders
function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input logic [4:0] sh,
                                       input logic [5:0] fn);
  return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] j_type(input logic [5:0] op, input int index);
  logic [31:0] target;
  target = reset_vector + index * 4;  // Word index within the program
  return {op, target[27:2]};
endfunction

task automatic emit(input logic [31:0] word);
  prog_rom[rom_fill] = word;
  rom_fill++;
endtask

task automatic open_test(input int t, input string name, input bit stall,
                         input logic [31:0] v0, input logic [31:0] v3);
  test_names[t] = name;
  stall_on[t]   = stall;
  exp_v0[t]     = v0;
  exp_v3[t]     = v3;
  prog_start[t] = rom_fill;
  init_addr[t]  = 32'h0;
  init_word[t]  = 32'h0;
  mem_chk_on[t] = 1'b0;
  mem_chk_addr[t] = 32'h0;
  mem_chk_word[t] = 32'h0;
  exp_loads[t]  = 0;
endtask

task automatic close_test(input int t);
  prog_len[t] = rom_fill - prog_start[t];
endtask

task automatic fill_table();
  rom_fill = 0;
  open_test(0, "r_type", 1'b0, 32'h2468ACF0, 32'hC1F1FF0F);
  emit(i_type(6'h0F, 0, 8, 16'h1234));    // lui t0, 0x1234
  emit(i_type(6'h0D, 8, 8, 16'h5678));    // ori t0 -> 12345678
  emit(i_type(6'h0F, 0, 9, 16'hF0F0));    // lui t1, 0xF0F0
  emit(i_type(6'h0D, 9, 9, 16'h0F0F));    // ori t1 -> F0F00F0F
  emit(r_type(8, 9, 10, 0, 6'h21));       // addu -> 03246587
  emit(r_type(8, 9, 11, 0, 6'h23));       // subu -> 21444769
  emit(r_type(8, 9, 12, 0, 6'h24));       // and -> 10300608
  emit(r_type(8, 9, 13, 0, 6'h25));       // or -> F2F45F7F
  emit(r_type(12, 13, 14, 0, 6'h26));     // xor -> E2C45977
  emit(r_type(9, 8, 15, 0, 6'h2A));       // slt, negative < positive -> 1
  emit(r_type(9, 8, 24, 0, 6'h2B));       // sltu -> 0
  emit(r_type(0, 8, 25, 4, 6'h00));       // sll 4 -> 23456780
  emit(r_type(0, 9, 16, 8, 6'h02));       // srl 8 -> 00F0F00F
  emit(r_type(10, 11, 2, 0, 6'h21));      // v0 -> 2468ACF0
  emit(r_type(14, 25, 3, 0, 6'h26));      // v3 -> C1813EF7
  emit(r_type(3, 16, 3, 0, 6'h25));       // v3 -> C1F1FEFF
  emit(r_type(0, 15, 15, 4, 6'h00));      // slt bit weighted to 0x10
  emit(r_type(3, 15, 3, 0, 6'h21));       // v3 -> C1F1FF0F
  emit(r_type(3, 24, 3, 0, 6'h21));       // sltu adds nothing
  emit(r_type(0, 0, 0, 0, 6'h08));        // jr zero, halt
  close_test(0);
  open_test(1, "immediate", 1'b0, 32'h00017FF1, 32'hFFFFFFFF);
  emit(i_type(6'h09, 0, 8, 16'hFFFE));    // addiu t0, -2 sign extended
  emit(i_type(6'h0C, 8, 9, 16'hFFF0));    // andi zero extends -> 0000FFF0
  emit(i_type(6'h0D, 0, 10, 16'h8001));   // ori -> 00008001
  emit(i_type(6'h09, 0, 0, 16'h0005));    // Write to register 0 is lost
  emit(i_type(6'h0A, 8, 12, 16'hFFFF));   // slti -2 < -1 -> 1
  emit(r_type(9, 10, 2, 0, 6'h21));       // v0 -> 00017FF1
  emit(r_type(8, 12, 3, 0, 6'h21));       // v3 -> FFFFFFFF
  emit(r_type(3, 0, 3, 0, 6'h21));        // Adds zero
  emit(r_type(0, 0, 0, 0, 6'h08));
  close_test(1);
  open_test(2, "load_store", 1'b0, 32'h1234ABCD, 32'hFE3C8000);
  init_addr[2]    = 32'h40;
  init_word[2]    = 32'h7F80C301;         // Bytes 40..43 are 7F 80 C3 01
  mem_chk_on[2]   = 1'b1;
  mem_chk_addr[2] = 32'h20;
  mem_chk_word[2] = 32'hCDAB3412;         // 1234ABCD seen little-endian
  exp_loads[2]    = 6;                    // lw and five byte loads
  emit(i_type(6'h0F, 0, 8, 16'h1234));
  emit(i_type(6'h0D, 8, 8, 16'hABCD));
  emit(i_type(6'h2B, 0, 8, 16'h0020));    // sw t0, 0x20
  emit(i_type(6'h23, 0, 2, 16'h0020));    // lw v0, 0x20
  emit(i_type(6'h20, 0, 9, 16'h0041));    // lb -> FFFFFF80
  emit(i_type(6'h24, 0, 10, 16'h0041));   // lbu -> 00000080
  emit(i_type(6'h20, 0, 11, 16'h0040));   // lb -> 0000007F
  emit(i_type(6'h24, 0, 12, 16'h0042));   // lbu -> 000000C3
  emit(i_type(6'h20, 0, 13, 16'h0043));   // lb -> 00000001
  emit(r_type(9, 10, 3, 0, 6'h26));       // v3 -> FFFFFF00
  emit(r_type(0, 11, 11, 8, 6'h00));
  emit(r_type(3, 11, 3, 0, 6'h26));       // v3 -> FFFF8000
  emit(r_type(0, 12, 12, 16, 6'h00));
  emit(r_type(3, 12, 3, 0, 6'h26));       // v3 -> FF3C8000
  emit(r_type(0, 13, 13, 24, 6'h00));
  emit(r_type(3, 13, 3, 0, 6'h26));       // v3 -> FE3C8000
  emit(r_type(0, 0, 0, 0, 6'h08));
  close_test(2);
  open_test(3, "control_flow", 1'b0, 32'hBFC00034, 32'h0000001F);
  emit(i_type(6'h09, 0, 3, 16'h0000));    // Counter in v3
  emit(i_type(6'h09, 0, 8, 16'h0005));
  emit(i_type(6'h09, 0, 9, 16'h0005));
  emit(i_type(6'h04, 8, 9, 16'h0001));    // beq taken
  emit(i_type(6'h09, 2, 2, 16'h0100));    // Skipped
  emit(i_type(6'h09, 3, 3, 16'h0001));
  emit(i_type(6'h05, 8, 9, 16'h0001));    // bne not taken
  emit(i_type(6'h09, 3, 3, 16'h0002));
  emit(i_type(6'h04, 8, 0, 16'h0001));    // beq not taken
  emit(i_type(6'h09, 3, 3, 16'h0004));
  emit(i_type(6'h05, 8, 0, 16'h0001));    // bne taken
  emit(i_type(6'h09, 2, 2, 16'h0200));    // Skipped
  emit(j_type(6'h03, 16));                // jal to word 16
  emit(i_type(6'h09, 3, 3, 16'h0010));    // Return lands here
  emit(r_type(2, 31, 2, 0, 6'h21));       // v0 gets the link address
  emit(j_type(6'h02, 18));                // j over the subroutine
  emit(i_type(6'h09, 3, 3, 16'h0008));    // Subroutine body
  emit(r_type(31, 0, 0, 0, 6'h08));       // jr ra
  emit(r_type(0, 0, 0, 0, 6'h08));
  close_test(3);
  open_test(4, "halt", 1'b0, 32'h00000055, 32'h00000066);
  emit(i_type(6'h09, 0, 2, 16'h0055));
  emit(i_type(6'h09, 0, 3, 16'h0066));
  emit(r_type(0, 0, 0, 0, 6'h08));
  emit(i_type(6'h09, 2, 2, 16'h0077));    // Never reached
  close_test(4);
  // Program of test 0 again with random stalls
  open_test(5, "stalls", 1'b1, 32'h2468ACF0, 32'hC1F1FF0F);
  prog_start[5] = prog_start[0];
  prog_len[5]   = prog_len[0];
endtask

`endif

//--- test/mips_cpu_harvard_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mips_cpu_harvard_tb;

  localparam logic [31:0] reset_vector = 32'hBFC00000;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic [31:0] instr_readdata;
  logic [31:0] data_readdata;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] register_v3;
  logic [31:0] instr_address;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;

  logic [31:0] imem [64];      // Little-endian words from reset_vector up
  logic [31:0] dmem [64];      // Little-endian words from address 0 up
  logic [31:0] halt_raw;       // Word at address 0
  logic [31:0] instr_offset;
  logic [31:0] lcg_state = 32'd70;
  logic [31:0] prev_addr = 32'h0;
  logic        prev_en = 1'b0;
  logic        prev_valid = 1'b0;
  bit          stall_now = 1'b0;
  int          cur_test = 0;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 100;
  int          loads = 0;

  `include "program_table.svh"

  mips_cpu_harvard #(
    .reset_vector (reset_vector)
  ) mips_cpu_harvard_inst (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .instr_readdata (instr_readdata),
    .data_readdata  (data_readdata),
    .active         (active),
    .register_v0    (register_v0),
    .register_v3    (register_v3),
    .instr_address  (instr_address),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata)
  );

  always #2 clk = ~clk;

  // Combinational memories
  assign instr_offset   = instr_address - reset_vector;
  assign instr_readdata = (instr_address == 32'h0) ? halt_raw :
                          (instr_offset < 32'd256) ? imem[instr_offset[7:2]] : 32'h0;
  assign data_readdata  = dmem[data_address[7:2]];

  always @(posedge clk) begin
    if (data_write) dmem[data_address[7:2]] <= data_writedata;  // Store lands at the edge
  end

  // Loads retired at enabled edges
  always @(posedge clk) begin
    if (data_read && clk_enable) loads++;
  end

  function automatic logic [31:0] byte_swap(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s %s: expected %h, actual %h",
               test_names[cur_test], what, expected, actual);
    end
  endtask

  task automatic load_memories(input int t);
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'h0;  // Unused words decode as nop
      dmem[i] = 32'h0;
    end
    for (int i = 0; i < prog_len[t]; i++) begin
      imem[i] = byte_swap(prog_rom[prog_start[t] + i]);
    end
    dmem[init_addr[t][7:2]] = byte_swap(init_word[t]);
    halt_raw = byte_swap(i_type(6'h09, 2, 2, 16'h0001));  // addiu v0, v0, 1
  endtask

  // clk_enable source, random gaps only in stall tests
  always @(posedge clk) begin
    if (stall_now) begin
      lcg_state = lcg_next(lcg_state);
      clk_enable <= (lcg_state[17:16] != 2'b00);  // About one gap in four
    end else begin
      clk_enable <= 1'b1;
    end
  end

  // Fetch address must hold across a stalled edge
  always @(posedge clk) begin
    if (prev_valid && !prev_en) compare("instr_address on stall", prev_addr, instr_address);
    prev_en    = clk_enable;
    prev_addr  = instr_address;
    prev_valid = !reset;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: test %s did not halt within %0d cycles",
               test_names[cur_test], cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int total_words;
    clk            = 1'b0;
    reset          = 1'b1;
    clk_enable     = 1'b0;
    total_words    = 0;
    fill_table();
    for (int t = 0; t < num_tests; t++) begin
      total_words += prog_len[t];
    end
    cycle_limit = total_words * 4 + 100;
    for (int t = 0; t < num_tests; t++) begin
      cur_test  <= t;
      stall_now <= stall_on[t];
      reset     <= 1'b1;
      load_memories(t);
      loads = 0;
      repeat (4) @(posedge clk);
      compare("active after reset", 32'd1, {31'h0, active});
      reset <= 1'b0;
      while (active !== 1'b0) @(posedge clk);  // Halt at address 0
      repeat (3) @(posedge clk);               // Halted core must stay put
      compare("v0", exp_v0[t], register_v0);
      compare("v3", exp_v3[t], register_v3);
      compare("active after halt", 32'd0, {31'h0, active});
      compare("data_write after halt", 32'd0, {31'h0, data_write});
      compare("load cycles", exp_loads[t], loads);
      if (mem_chk_on[t]) begin
        compare("stored word", mem_chk_word[t], dmem[mem_chk_addr[t][7:2]]);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+test
common/mips_pkg.sv
common/ctrl_if.sv
datapath/reg_file.sv
datapath/alu.sv
datapath/datapath.sv
source/controller.sv
source/mips_cpu_harvard.sv
test/mips_cpu_harvard_tb.sv

//--- Bender.yml
package:
  name: mips_cpu_harvard

sources:
  - common/mips_pkg.sv
  - common/ctrl_if.sv
  - datapath/reg_file.sv
  - datapath/alu.sv
  - datapath/datapath.sv
  - source/controller.sv
  - source/mips_cpu_harvard.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/mips_cpu_harvard_tb.sv
